// File: logic/bm_defs.svh
`ifndef BM_DEFS_SVH
`define BM_DEFS_SVH

// ====================
// mode timing
// ====================
// horizontal counts in clocks
`define BM_H_TOTAL       96
`define BM_H_ACTIVE      64
`define BM_HS_START      72
`define BM_HS_END        80
// vertical counts in lines
`define BM_V_TOTAL       14
`define BM_V_ACTIVE      8
`define BM_VS_START      10
`define BM_VS_END        12
// beam and row field widths
`define BM_HPOS_W        7
`define BM_VPOS_W        4
`define BM_ROW_W         3

// ====================
// fetch geometry
// ====================
`define BM_WORDS_PER_ROW 16
`define BM_BURST_LEN     8
`define BM_BASE_ADDR0    32'h0010_0000
`define BM_BASE_ADDR1    32'h0014_0000
`define BM_CTI_CLASSIC   3'b000
`define BM_CTI_INCR      3'b010
`define BM_CTI_END       3'b111
`endif

// File: logic/bm_bus_pkg.sv
`default_nettype none

package bm_bus_pkg;

	// one memory word, either as raw bus data or as four pixels
	// byte 0 sits in bits 7:0 and is the leftmost pixel
	typedef union packed {
		logic [31:0]     raw;
		logic [3:0][7:0] bytes;
	} pix_word_u;

endpackage

`default_nettype wire

// File: logic/bm_ifs.sv
`timescale 1ns/1ps
`default_nettype none
`include "bm_defs.svh"

// ====================
// beam position and timing strobes
// ====================
interface beam_if;
	logic [`BM_HPOS_W-1:0] hpos;
	logic [`BM_VPOS_W-1:0] vpos;
	logic                  active;
	logic                  hsync;
	logic                  vsync;
	// one-cycle request for the row shown on the next line
	logic                  fetch_go;
	logic [`BM_ROW_W-1:0]  fetch_row;
	// one line ahead of the frame
	logic                  frame_arm;

	modport timer (output hpos, vpos, active, hsync, vsync, fetch_go, fetch_row, frame_arm);
	modport sink (input hpos, vpos, active, hsync, vsync, fetch_go, fetch_row, frame_arm);
endinterface

// ====================
// line buffer write port
// ====================
interface line_fill_if import bm_bus_pkg::*; ();
	logic      we;
	logic      half;
	logic [3:0] word_idx;
	pix_word_u data;

	modport wr (output we, half, word_idx, data);
	modport rd (input we, half, word_idx, data);
endinterface

`default_nettype wire

// File: logic/bm_beam_timer.sv
`timescale 1ns/1ps
`default_nettype none
`include "bm_defs.svh"

module bm_beam_timer (
	input  logic  vclk,
	input  logic  rst_i,
	beam_if.timer beam
);

	localparam logic [`BM_HPOS_W-1:0] H_LAST = `BM_HPOS_W'(`BM_H_TOTAL - 1);
	localparam logic [`BM_VPOS_W-1:0] V_LAST = `BM_VPOS_W'(`BM_V_TOTAL - 1);

	logic [`BM_HPOS_W-1:0] hcnt;
	logic [`BM_VPOS_W-1:0] vcnt;
	logic                  line_start;
	logic                  last_line;

	// ====================
	// counters
	// ====================
	// pixel counter wraps at the line total, line counter steps on that wrap
	always_ff @(posedge vclk) begin
		if (rst_i) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (hcnt == H_LAST) begin
			hcnt <= '0;
			if (vcnt == V_LAST)
				vcnt <= '0;
			else
				vcnt <= vcnt + 1'b1;
		end else begin
			hcnt <= hcnt + 1'b1;
		end
	end

	assign line_start = (hcnt == '0);
	assign last_line  = (vcnt == V_LAST);

	// ranges straight from the counts
	assign beam.hpos   = hcnt;
	assign beam.vpos   = vcnt;
	assign beam.active = (hcnt < `BM_H_ACTIVE) && (vcnt < `BM_V_ACTIVE);
	assign beam.hsync  = (hcnt >= `BM_HS_START) && (hcnt < `BM_HS_END);
	assign beam.vsync  = (vcnt >= `BM_VS_START) && (vcnt < `BM_VS_END);

	// next line visible when on the last line or on rows 0 .. V_ACTIVE-2
	assign beam.fetch_go  = line_start && (last_line || (vcnt < `BM_V_ACTIVE - 1));
	// row 0 comes after the last line, otherwise the next row
	assign beam.fetch_row = last_line ? '0 : `BM_ROW_W'(vcnt + 1'b1);
	assign beam.frame_arm = line_start && last_line;

endmodule

`default_nettype wire

// File: logic/bm_fetch_master.sv
`timescale 1ns/1ps
`default_nettype none
`include "bm_defs.svh"

module bm_fetch_master (
	input  logic        vclk,
	input  logic        rst_i,
	beam_if.sink        beam,
	input  logic        page_i,
	input  logic        onoff_i,
	output logic        cyc_o,
	output logic        stb_o,
	output logic [31:0] adr_o,
	output logic [2:0]  cti_o,
	input  logic        ack_i,
	input  logic [31:0] dat_i,
	output logic        on_o,
	line_fill_if.wr     fill
);

	localparam logic [2:0]  BEAT_LAST   = 3'(`BM_BURST_LEN - 1);
	localparam logic [31:0] ROW_BYTES   = 32'(`BM_WORDS_PER_ROW * 4);
	localparam logic [31:0] BURST_BYTES = 32'(`BM_BURST_LEN * 4);

	logic                 go_q;
	logic [`BM_ROW_W-1:0] row_q;
	logic                 page_q;
	logic                 on_q;
	// second burst of the row still to go
	logic                 pend_q;
	logic                 burst_q;
	logic [2:0]           beat_q;
	logic [31:0]          base_addr;
	logic [31:0]          start_addr;
	logic                 start_first;
	logic                 start_next;

	assign base_addr   = page_q ? `BM_BASE_ADDR1 : `BM_BASE_ADDR0;
	// an off frame never opens a cycle
	assign start_first = go_q & on_q & ~cyc_o;
	assign start_next  = pend_q & ~cyc_o;
	assign start_addr  = base_addr + 32'(row_q) * ROW_BYTES + (start_next ? BURST_BYTES : '0);

	// ====================
	// burst engine
	// ====================
	always_ff @(posedge vclk) begin
		if (rst_i) begin
			go_q    <= 1'b0;
			row_q   <= '0;
			page_q  <= 1'b0;
			on_q    <= 1'b0;
			pend_q  <= 1'b0;
			burst_q <= 1'b0;
			beat_q  <= '0;
			cyc_o   <= 1'b0;
			stb_o   <= 1'b0;
			adr_o   <= '0;
			cti_o   <= `BM_CTI_CLASSIC;
		end else begin
			go_q <= beam.fetch_go;
			if (beam.fetch_go)
				row_q <= beam.fetch_row;
			// controls hold for the whole next frame
			if (beam.frame_arm) begin
				page_q <= page_i;
				on_q   <= onoff_i;
			end
			if (start_first | start_next) begin
				cyc_o   <= 1'b1;
				stb_o   <= 1'b1;
				adr_o   <= start_addr;
				cti_o   <= `BM_CTI_INCR;
				beat_q  <= '0;
				burst_q <= start_next;
				pend_q  <= 1'b0;
			end else if (cyc_o & ack_i) begin
				beat_q <= beat_q + 1'b1;
				adr_o  <= adr_o + 32'd4;
				// flag end of burst on the word about to go out
				if (beat_q == BEAT_LAST - 1'b1)
					cti_o <= `BM_CTI_END;
				if (beat_q == BEAT_LAST) begin
					cyc_o  <= 1'b0;
					stb_o  <= 1'b0;
					cti_o  <= `BM_CTI_CLASSIC;
					pend_q <= ~burst_q;
				end
			end
		end
	end

	// ====================
	// buffer write, one cycle behind the ack
	// ====================
	always_ff @(posedge vclk) begin
		if (rst_i)
			fill.we <= 1'b0;
		else
			fill.we <= cyc_o & ack_i;
	end

	always_ff @(posedge vclk) begin
		fill.half     <= row_q[0];
		fill.word_idx <= {burst_q, beat_q};
		fill.data.raw <= dat_i;
	end

	assign on_o = on_q;

endmodule

`default_nettype wire

// File: logic/bm_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "bm_defs.svh"

module bm_line_buffer
	import bm_bus_pkg::*;
(
	input  logic       vclk,
	line_fill_if.rd    fill,
	beam_if.sink       beam,
	output logic [7:0] pix_o
);

	// two halves, one per row parity
	localparam int DEPTH = 2 * `BM_WORDS_PER_ROW;

	pix_word_u  mem [DEPTH];
	// half, word, byte
	logic [6:0] rd_adr;
	pix_word_u  rd_word;

	// ====================
	// write side
	// ====================
	always_ff @(posedge vclk) begin
		if (fill.we)
			mem[{fill.half, fill.word_idx}] <= fill.data;
	end

	// ====================
	// read side
	// ====================
	// displayed row sits in the half picked by vpos bit 0
	always_ff @(posedge vclk) begin
		rd_adr <= {beam.vpos[0], beam.hpos[5:0]};
	end

	assign rd_word = mem[rd_adr[6:2]];
	assign pix_o   = rd_word.bytes[rd_adr[1:0]];

endmodule

`default_nettype wire

// File: logic/bm_pixel_out.sv
`timescale 1ns/1ps
`default_nettype none

module bm_pixel_out (
	input  logic       vclk,
	input  logic       rst_i,
	beam_if.sink       beam,
	input  logic [7:0] pix_i,
	input  logic       on_i,
	output logic       hsync_o,
	output logic       vsync_o,
	output logic       blank_o,
	output logic [7:0] rgb_o
);

	// first stage lines up with the buffer read
	logic active_d;
	logic hsync_d;
	logic vsync_d;

	always_ff @(posedge vclk) begin
		if (rst_i) begin
			active_d <= 1'b0;
			hsync_d  <= 1'b0;
			vsync_d  <= 1'b0;
			hsync_o  <= 1'b0;
			vsync_o  <= 1'b0;
			blank_o  <= 1'b1;
			rgb_o    <= '0;
		end else begin
			active_d <= beam.active;
			hsync_d  <= beam.hsync;
			vsync_d  <= beam.vsync;
			// output stage, pixel forced dark outside the picture or when off
			hsync_o  <= hsync_d;
			vsync_o  <= vsync_d;
			blank_o  <= ~active_d;
			rgb_o    <= (active_d && on_i) ? pix_i : 8'h00;
		end
	end

endmodule

`default_nettype wire

// File: logic/bitmap_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module bitmap_ctrl_top (
	input  logic        vclk,
	input  logic        rst_i,
	// memory bus master
	output logic        cyc_o,
	output logic        stb_o,
	output logic [31:0] adr_o,
	output logic [2:0]  cti_o,
	input  logic        ack_i,
	input  logic [31:0] dat_i,
	// controls
	input  logic        page_i,
	input  logic        onoff_i,
	// video
	output logic        hsync_o,
	output logic        vsync_o,
	output logic        blank_o,
	output logic [7:0]  rgb_o
);

	logic [7:0] pix;
	logic       frame_on;

	beam_if      beam ();
	line_fill_if fill ();

	// ====================
	// pipeline stages
	// ====================
	bm_beam_timer i_timer (
		.vclk  (vclk),
		.rst_i (rst_i),
		.beam  (beam)
	);

	bm_fetch_master i_fetch (
		.vclk    (vclk),
		.rst_i   (rst_i),
		.beam    (beam),
		.page_i  (page_i),
		.onoff_i (onoff_i),
		.cyc_o   (cyc_o),
		.stb_o   (stb_o),
		.adr_o   (adr_o),
		.cti_o   (cti_o),
		.ack_i   (ack_i),
		.dat_i   (dat_i),
		.on_o    (frame_on),
		.fill    (fill)
	);

	bm_line_buffer i_lbuf (
		.vclk  (vclk),
		.fill  (fill),
		.beam  (beam),
		.pix_o (pix)
	);

	bm_pixel_out i_pix (
		.vclk    (vclk),
		.rst_i   (rst_i),
		.beam    (beam),
		.pix_i   (pix),
		.on_i    (frame_on),
		.hsync_o (hsync_o),
		.vsync_o (vsync_o),
		.blank_o (blank_o),
		.rgb_o   (rgb_o)
	);

endmodule

`default_nettype wire

// File: bench/bm_bus_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "bm_defs.svh"

module bm_bus_checker (
	input  logic        vclk,
	input  logic        rst_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic [31:0] adr_i,
	input  logic [2:0]  cti_i,
	input  logic        ack_i
);

	// words already acknowledged in the open burst
	logic [2:0] beat;
	// failed assertions, read by the testbench at the end
	int         fail_cnt = 0;

	always_ff @(posedge vclk) begin
		if (rst_i || !cyc_i)
			beat <= '0;
		else if (stb_i && ack_i)
			beat <= beat + 1'b1;
	end

	// ====================
	// bus protocol
	// ====================
	a_stb_cyc: assert property (@(posedge vclk) disable iff (rst_i) stb_i == cyc_i)
		else begin
			fail_cnt++;
			$error("stb_o and cyc_o differ");
		end

	// a stalled request holds address and cycle type
	a_hold: assert property (@(posedge vclk) disable iff (rst_i)
		stb_i && !ack_i |=> $stable(adr_i) && $stable(cti_i))
		else begin
			fail_cnt++;
			$error("adr_o or cti_o moved while waiting for ack_i");
		end

	// incrementing burst, one word per ack
	a_incr: assert property (@(posedge vclk) disable iff (rst_i)
		stb_i && ack_i && cti_i != `BM_CTI_END |=> adr_i == $past(adr_i) + 32'd4)
		else begin
			fail_cnt++;
			$error("adr_o did not advance by one word after ack_i");
		end

	// end of burst on the eighth word and nowhere else
	a_end: assert property (@(posedge vclk) disable iff (rst_i)
		stb_i |-> ((cti_i == `BM_CTI_END) == (beat == 3'(`BM_BURST_LEN - 1))))
		else begin
			fail_cnt++;
			$error("cti_o end of burst not on the last word");
		end

endmodule

bind bm_fetch_master bm_bus_checker i_bus_chk (
	.vclk  (vclk),
	.rst_i (rst_i),
	.cyc_i (cyc_o),
	.stb_i (stb_o),
	.adr_i (adr_o),
	.cti_i (cti_o),
	.ack_i (ack_i)
);

`default_nettype wire

// File: bench/bm_monitor.sv
`timescale 1ns/1ps
`default_nettype none
`include "bm_defs.svh"

module bm_monitor (
	input  logic        vclk,
	input  logic        rst_i,
	input  logic        hsync_i,
	input  logic        vsync_i,
	input  logic        blank_i,
	input  logic [7:0]  rgb_i,
	input  logic        cyc_i,
	input  logic [31:0] adr_i,
	input  logic        ack_i,
	input  logic        page_i,
	input  logic        onoff_i,
	output int          frames_o,
	output int          pix_errs_o,
	output int          tim_errs_o,
	output int          off_errs_o,
	output int          adr_errs_o
);

	localparam int HS_WIDTH = `BM_HS_END - `BM_HS_START;
	// vsync counted in clocks
	localparam int VS_WIDTH = (`BM_VS_END - `BM_VS_START) * `BM_H_TOTAL;

	logic        hsync_q = 1'b0;
	logic        vsync_q = 1'b0;
	logic        blank_q = 1'b1;
	// frame under check, with the controls it was armed with
	logic        in_frame = 1'b0;
	logic        frm_page = 1'b0;
	logic        frm_on = 1'b0;
	logic        cyc_flagged = 1'b0;
	int          x = 0;
	int          y = 0;
	int          hs_w = 0;
	int          vs_w = 0;
	// words acknowledged so far in the frame
	int          words = 0;
	int          frames = 0;
	int          pix_errs = 0;
	int          tim_errs = 0;
	int          off_errs = 0;
	int          adr_errs = 0;
	logic [7:0]  exp_pix;
	logic [31:0] exp_adr;

	// pixel byte = low address byte xor next byte, dark when the frame is off
	function automatic logic [7:0] expected_pixel(input logic page, input logic on,
			input int px, input int py);
		logic [31:0] adr;
		adr = (page ? `BM_BASE_ADDR1 : `BM_BASE_ADDR0) + 32'(py * `BM_H_ACTIVE + px);
		return on ? (adr[7:0] ^ adr[15:8]) : 8'h00;
	endfunction

	// ====================
	// compare
	// ====================
	always @(posedge vclk) begin
		if (!rst_i) begin
			// visible pixels and line width
			if (!blank_i) begin
				if (in_frame) begin
					exp_pix = expected_pixel(frm_page, frm_on, x, y);
					if (rgb_i !== exp_pix) begin
						pix_errs++;
						$display("Fail pixel f%0d x%0d y%0d: expected %02h, actual %02h",
							frames + 1, x, y, exp_pix, rgb_i);
					end
				end
				x++;
			end else if (!blank_q) begin
				if (x != `BM_H_ACTIVE) begin
					tim_errs++;
					$display("Fail line_width: expected %0d, actual %0d", `BM_H_ACTIVE, x);
				end
				x = 0;
				y++;
			end
			// hsync width per line
			if (hsync_i) begin
				hs_w++;
			end else if (hsync_q) begin
				if (hs_w != HS_WIDTH) begin
					tim_errs++;
					$display("Fail hsync_width: expected %0d, actual %0d", HS_WIDTH, hs_w);
				end
				hs_w = 0;
			end
			// vsync closes the frame on its rise
			if (vsync_i) begin
				if (!vsync_q && in_frame) begin
					if (y != `BM_V_ACTIVE) begin
						tim_errs++;
						$display("Fail lines_per_frame: expected %0d, actual %0d",
							`BM_V_ACTIVE, y);
					end
					frames++;
					in_frame = 1'b0;
				end
				vs_w++;
			end else if (vsync_q) begin
				if (vs_w != VS_WIDTH) begin
					tim_errs++;
					$display("Fail vsync_width: expected %0d, actual %0d", VS_WIDTH, vs_w);
				end
				vs_w = 0;
				// controls were set during vsync, they hold for the coming frame
				frm_page = page_i;
				frm_on = onoff_i;
				in_frame = 1'b1;
				cyc_flagged = 1'b0;
				words = 0;
				y = 0;
			end
			// an off frame must leave the bus idle
			if (in_frame && !frm_on && cyc_i && !cyc_flagged) begin
				off_errs++;
				cyc_flagged = 1'b1;
				$display("bus cycle started during an off frame (frame %0d)", frames + 1);
			end
			// rows come in order, so the frame reads its page as one run of words
			if (in_frame && frm_on && cyc_i && ack_i) begin
				exp_adr = (frm_page ? `BM_BASE_ADDR1 : `BM_BASE_ADDR0) + 32'(words * 4);
				if (adr_i !== exp_adr) begin
					adr_errs++;
					$display("Fail fetch_addr f%0d word %0d: expected %08h, actual %08h",
						frames + 1, words, exp_adr, adr_i);
				end
				words++;
			end
			hsync_q = hsync_i;
			vsync_q = vsync_i;
			blank_q = blank_i;
		end
	end

	assign frames_o   = frames;
	assign pix_errs_o = pix_errs;
	assign tim_errs_o = tim_errs;
	assign off_errs_o = off_errs;
	assign adr_errs_o = adr_errs;

endmodule

`default_nettype wire

// File: bench/tb_bitmap.sv
`timescale 1ns/1ps
`default_nettype none
`include "bm_defs.svh"

module tb_bitmap;

	localparam int FRAME_CYCLES = `BM_H_TOTAL * `BM_V_TOTAL;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_FRAMES   = 6;
	// one spare frame covers the partial frame after reset
	localparam int CYCLE_LIMIT  = (NUM_FRAMES + 1) * FRAME_CYCLES + RESET_CYCLES;
	// frame settings, bit i for frame i
	localparam logic [NUM_FRAMES-1:0] PAGE_SEQ = 6'b011010;
	localparam logic [NUM_FRAMES-1:0] ON_SEQ   = 6'b111011;

	logic        vclk = 1'b0;
	logic        rst_i = 1'b1;
	logic        ack_i = 1'b0;
	logic [31:0] dat_i = '0;
	logic        page_i = 1'b0;
	logic        onoff_i = 1'b1;
	logic        cyc_o;
	logic        stb_o;
	logic [31:0] adr_o;
	logic [2:0]  cti_o;
	logic        hsync_o;
	logic        vsync_o;
	logic        blank_o;
	logic [7:0]  rgb_o;
	logic [31:0] lfsr = 32'hfd1f;
	logic        stalled = 1'b0;
	int          cycles = 0;
	int          frames;
	int          pix_errs;
	int          tim_errs;
	int          off_errs;
	int          adr_errs;

	always #5 vclk = ~vclk;

	bitmap_ctrl_top i_dut (
		.vclk    (vclk),
		.rst_i   (rst_i),
		.cyc_o   (cyc_o),
		.stb_o   (stb_o),
		.adr_o   (adr_o),
		.cti_o   (cti_o),
		.ack_i   (ack_i),
		.dat_i   (dat_i),
		.page_i  (page_i),
		.onoff_i (onoff_i),
		.hsync_o (hsync_o),
		.vsync_o (vsync_o),
		.blank_o (blank_o),
		.rgb_o   (rgb_o)
	);

	bm_monitor i_mon (
		.vclk       (vclk),
		.rst_i      (rst_i),
		.hsync_i    (hsync_o),
		.vsync_i    (vsync_o),
		.blank_i    (blank_o),
		.rgb_i      (rgb_o),
		.cyc_i      (cyc_o),
		.adr_i      (adr_o),
		.ack_i      (ack_i),
		.page_i     (page_i),
		.onoff_i    (onoff_i),
		.frames_o   (frames),
		.pix_errs_o (pix_errs),
		.tim_errs_o (tim_errs),
		.off_errs_o (off_errs),
		.adr_errs_o (adr_errs)
	);

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// byte k of the word at A is (A+k) low byte xor (A+k) second byte
	function automatic logic [31:0] memory_word(input logic [31:0] adr);
		logic [31:0] a;
		logic [31:0] w;
		for (int k = 0; k < 4; k++) begin
			a = adr + 32'(k);
			w[8*k +: 8] = a[7:0] ^ a[15:8];
		end
		return w;
	endfunction

	// waits on clock edges, looks 1 ns after each
	task automatic wait_vsync(input logic level);
		do begin
			@(posedge vclk);
			#1;
		end while (vsync_o !== level);
	endtask

	// ====================
	// memory responder
	// ====================
	// random ack, never two stalls in a row
	always @(posedge vclk) begin
		#1;
		if (!rst_i && cyc_o && stb_o) begin
			if (stalled) begin
				ack_i = 1'b1;
			end else begin
				lfsr = lfsr_step(lfsr);
				ack_i = lfsr[0];
			end
			stalled = ~ack_i;
			dat_i = memory_word(adr_o);
		end else begin
			ack_i = 1'b0;
			stalled = 1'b0;
		end
	end

	// ====================
	// timeout
	// ====================
	always @(posedge vclk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not end within %0d cycles, %0d of %0d frames checked",
				CYCLE_LIMIT, frames, NUM_FRAMES);
			$display("Test FAILED");
			$finish;
		end
	end

	// ====================
	// stimulus
	// ====================
	initial begin
		int bus_errs;
		repeat (RESET_CYCLES) @(posedge vclk);
		#1;
		rst_i = 1'b0;
		// each setting goes in during vsync and holds for the frame after it
		for (int i = 0; i < NUM_FRAMES; i++) begin
			wait_vsync(1'b1);
			page_i = PAGE_SEQ[i];
			onoff_i = ON_SEQ[i];
			wait_vsync(1'b0);
		end
		while (frames < NUM_FRAMES)
			@(posedge vclk);
		bus_errs = i_dut.i_fetch.i_bus_chk.fail_cnt;
		$display("errors: pixel %0d, timing %0d, off-frame bus %0d, fetch address %0d, %s %0d",
			pix_errs, tim_errs, off_errs, adr_errs, "bus protocol", bus_errs);
		if (pix_errs + tim_errs + off_errs + adr_errs + bus_errs == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/bm_bus_pkg.sv
logic/bm_ifs.sv
logic/bm_beam_timer.sv
logic/bm_fetch_master.sv
logic/bm_line_buffer.sv
logic/bm_pixel_out.sv
logic/bitmap_ctrl_top.sv
bench/bm_bus_checker.sv
bench/bm_monitor.sv
bench/tb_bitmap.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_bitmap
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_ARGS  = +verilator+error+limit+1000

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
